// File: design/sysu_dq_cfg_pkg.sv
/* sizing for the system unit dispatch queue
   queue depth, dispatch ways, register file, ROB and writeback banks */

package sysu_dq_cfg_pkg;

    // --------------------------------------------------
    // queue and dispatch
    localparam int SYSU_DQ_ENTRIES = 4;
    localparam int DISPATCH_WAYS = 4;

    // --------------------------------------------------
    // physical register file
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

    // writeback bus is banked on the low register bits
    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    // --------------------------------------------------
    // reorder buffer
    localparam int ROB_ENTRIES = 64;
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

endpackage

// File: design/sysu_op_pkg.sv
/* op field and index types for the system unit dispatch queue
   plus the operand-need rule decoded from the op bits */

package sysu_op_pkg;

    // --------------------------------------------------
    // op fields
    typedef logic [3:0] sysu_op_t;
    typedef logic [11:0] imm12_t;

    // register and ROB indices
    typedef logic [sysu_dq_cfg_pkg::LOG_PR_COUNT-1:0] pr_t;
    typedef logic [sysu_dq_cfg_pkg::LOG_PR_COUNT-sysu_dq_cfg_pkg::LOG_PRF_BANK_COUNT-1:0]
        pr_upper_t;
    typedef logic [sysu_dq_cfg_pkg::LOG_ROB_ENTRIES-1:0] rob_index_t;

    // masks
    typedef logic [sysu_dq_cfg_pkg::SYSU_DQ_ENTRIES-1:0] entry_mask_t;
    typedef logic [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] way_mask_t;

    // --------------------------------------------------
    // operand need, no separate decode flags
    // op[1:0] == 0 covers ecall/ebreak/wfi/ret forms
    function automatic logic op_needs_a(sysu_op_t op);
        return op[1:0] != 2'b00;
    endfunction

    // immediate csr forms (op[2] set) read A only
    function automatic logic op_needs_b(sysu_op_t op);
        return op_needs_a(op) && !op[2];
    endfunction

endpackage

// File: design/sysu_dq_alloc_if.sv
/* allocator to entry array bundle
   per-entry dispatch writes one way, free mask back */

`timescale 1ns/10ps

interface sysu_dq_alloc_if;
    import sysu_dq_cfg_pkg::*;
    import sysu_op_pkg::*;

    // per-entry writes, one-hot across ways
    entry_mask_t write_mask;
    entry_mask_t write_valid;
    sysu_op_t [SYSU_DQ_ENTRIES-1:0] write_op;
    imm12_t [SYSU_DQ_ENTRIES-1:0] write_imm12;
    pr_t [SYSU_DQ_ENTRIES-1:0] write_a_pr;
    entry_mask_t write_a_ready;
    pr_t [SYSU_DQ_ENTRIES-1:0] write_b_pr;
    entry_mask_t write_b_ready;
    pr_t [SYSU_DQ_ENTRIES-1:0] write_dest_pr;
    rob_index_t [SYSU_DQ_ENTRIES-1:0] write_rob_index;

    // empty entries at the start of the cycle
    entry_mask_t free_mask;

    modport alloc (
        output write_mask, write_valid, write_op, write_imm12, write_a_pr, write_a_ready,
        output write_b_pr, write_b_ready, write_dest_pr, write_rob_index,
        input  free_mask
    );

    modport entries (
        input  write_mask, write_valid, write_op, write_imm12, write_a_pr, write_a_ready,
        input  write_b_pr, write_b_ready, write_dest_pr, write_rob_index,
        output free_mask
    );

endinterface

// File: design/sysu_dq_alloc.sv
/* dispatch allocator for the system unit queue
   per-way lowest free entry claim, acks, payload crossbar to entries */

`timescale 1ns/10ps

module sysu_dq_alloc (
    // dispatch by way
    input  sysu_op_pkg::way_mask_t                                       attempt,
    input  sysu_op_pkg::way_mask_t                                       dispatch_valid,
    input  sysu_op_pkg::sysu_op_t   [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] op,
    input  sysu_op_pkg::imm12_t     [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] imm12,
    input  sysu_op_pkg::pr_t        [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] a_pr,
    input  sysu_op_pkg::way_mask_t                                       a_ready,
    input  sysu_op_pkg::pr_t        [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] b_pr,
    input  sysu_op_pkg::way_mask_t                                       b_ready,
    input  sysu_op_pkg::pr_t        [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] dest_pr,
    input  sysu_op_pkg::rob_index_t [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] rob_index,

    // dispatch feedback
    output sysu_op_pkg::way_mask_t                                       ack,

    // writes toward the entry array
    sysu_dq_alloc_if.alloc                                               alloc
);
    import sysu_dq_cfg_pkg::*;
    import sysu_op_pkg::*;

    // entry claimed by each way, one-hot or zero
    entry_mask_t [DISPATCH_WAYS-1:0] pick_by_way;

    // --------------------------------------------------
    // claim chain, way 0 has priority
    always_comb begin
        entry_mask_t remaining;

        remaining = alloc.free_mask;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            pick_by_way[w] = '0;
            if (attempt[w]) begin
                // walk down so the lowest open entry wins
                for (int e = SYSU_DQ_ENTRIES - 1; e >= 0; e--) begin
                    if (remaining[e]) begin
                        pick_by_way[w] = entry_mask_t'(1'b1) << e;
                    end
                end
            end
            ack[w] = |pick_by_way[w];
            remaining = remaining & ~pick_by_way[w];
        end
    end

    // --------------------------------------------------
    // route way payloads onto claimed entries
    // picks are one-hot per entry so OR acts as a mux
    always_comb begin
        alloc.write_mask = '0;
        alloc.write_valid = '0;
        alloc.write_op = '0;
        alloc.write_imm12 = '0;
        alloc.write_a_pr = '0;
        alloc.write_a_ready = '0;
        alloc.write_b_pr = '0;
        alloc.write_b_ready = '0;
        alloc.write_dest_pr = '0;
        alloc.write_rob_index = '0;

        for (int e = 0; e < SYSU_DQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (pick_by_way[w][e]) begin
                    alloc.write_mask[e] = 1'b1;
                    alloc.write_valid[e] |= dispatch_valid[w];
                    alloc.write_op[e] |= op[w];
                    alloc.write_imm12[e] |= imm12[w];
                    alloc.write_a_pr[e] |= a_pr[w];
                    alloc.write_a_ready[e] |= a_ready[w];
                    alloc.write_b_pr[e] |= b_pr[w];
                    alloc.write_b_ready[e] |= b_ready[w];
                    alloc.write_dest_pr[e] |= dest_pr[w];
                    alloc.write_rob_index[e] |= rob_index[w];
                end
            end
        end
    end

endmodule

// File: design/sysu_dq_entries.sv
/* in-order entry array of the system unit dispatch queue
   writeback wakeup, head launch, compaction toward entry 0 */

`timescale 1ns/10ps

module sysu_dq_entries (
    input  logic                                               CLK,
    input  logic                                               nRST,

    // dispatch writes in, free entries out
    sysu_dq_alloc_if.entries                                   alloc,

    // writeback bus by bank
    input  logic [sysu_dq_cfg_pkg::PRF_BANK_COUNT-1:0]         wb_valid,
    input  sysu_op_pkg::pr_upper_t [sysu_dq_cfg_pkg::PRF_BANK_COUNT-1:0] wb_upper_pr,

    // launch to the system unit
    input  logic                                               launch_ready,
    output logic                                               launch_valid,
    output sysu_op_pkg::sysu_op_t                              launch_op,
    output sysu_op_pkg::imm12_t                                launch_imm12,
    output sysu_op_pkg::pr_t                                   launch_a_pr,
    output sysu_op_pkg::pr_t                                   launch_b_pr,
    output sysu_op_pkg::pr_t                                   launch_dest_pr,
    output sysu_op_pkg::rob_index_t                            launch_rob_index
);
    import sysu_dq_cfg_pkg::*;
    import sysu_op_pkg::*;

    // stored entries
    entry_mask_t valid_q, valid_d;
    sysu_op_t [SYSU_DQ_ENTRIES-1:0] op_q, op_d;
    imm12_t [SYSU_DQ_ENTRIES-1:0] imm12_q, imm12_d;
    pr_t [SYSU_DQ_ENTRIES-1:0] a_pr_q, a_pr_d;
    entry_mask_t a_ready_q, a_ready_d;
    pr_t [SYSU_DQ_ENTRIES-1:0] b_pr_q, b_pr_d;
    entry_mask_t b_ready_q, b_ready_d;
    pr_t [SYSU_DQ_ENTRIES-1:0] dest_pr_q, dest_pr_d;
    rob_index_t [SYSU_DQ_ENTRIES-1:0] rob_index_q, rob_index_d;

    // ready including this cycle's writeback
    entry_mask_t a_ready_now;
    entry_mask_t b_ready_now;
    logic launching;

    // bank picked by low bits, upper bits compared on that bank
    function automatic logic wb_match(pr_t pr);
        logic [LOG_PRF_BANK_COUNT-1:0] bank;

        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return wb_valid[bank] && (wb_upper_pr[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    // --------------------------------------------------
    // wakeup and launch
    always_comb begin
        for (int i = 0; i < SYSU_DQ_ENTRIES; i++) begin
            a_ready_now[i] = a_ready_q[i] | wb_match(a_pr_q[i]);
            b_ready_now[i] = b_ready_q[i] | wb_match(b_pr_q[i]);
        end
    end

    assign launching = valid_q[0] & launch_ready
        & (~op_needs_a(op_q[0]) | a_ready_now[0])
        & (~op_needs_b(op_q[0]) | b_ready_now[0]);

    assign launch_valid = launching;
    assign launch_op = op_q[0];
    assign launch_imm12 = imm12_q[0];
    assign launch_a_pr = a_pr_q[0];
    assign launch_b_pr = b_pr_q[0];
    assign launch_dest_pr = dest_pr_q[0];
    assign launch_rob_index = rob_index_q[0];

    assign alloc.free_mask = ~valid_q;

    // --------------------------------------------------
    // next state: each entry sources itself, or the one above on launch
    always_comb begin
        valid_d = '0;
        op_d = op_q;
        imm12_d = imm12_q;
        a_pr_d = a_pr_q;
        a_ready_d = a_ready_q;
        b_pr_d = b_pr_q;
        b_ready_d = b_ready_q;
        dest_pr_d = dest_pr_q;
        rob_index_d = rob_index_q;

        for (int i = 0; i < SYSU_DQ_ENTRIES; i++) begin
            for (int s = 0; s < SYSU_DQ_ENTRIES; s++) begin
                if (s == i + int'(launching)) begin
                    if (valid_q[s]) begin
                        valid_d[i] = 1'b1;
                        op_d[i] = op_q[s];
                        imm12_d[i] = imm12_q[s];
                        a_pr_d[i] = a_pr_q[s];
                        a_ready_d[i] = a_ready_now[s];
                        b_pr_d[i] = b_pr_q[s];
                        b_ready_d[i] = b_ready_now[s];
                        dest_pr_d[i] = dest_pr_q[s];
                        rob_index_d[i] = rob_index_q[s];
                    end else if (alloc.write_mask[s]) begin
                        valid_d[i] = alloc.write_valid[s];
                        op_d[i] = alloc.write_op[s];
                        imm12_d[i] = alloc.write_imm12[s];
                        a_pr_d[i] = alloc.write_a_pr[s];
                        a_ready_d[i] = alloc.write_a_ready[s];
                        b_pr_d[i] = alloc.write_b_pr[s];
                        b_ready_d[i] = alloc.write_b_ready[s];
                        dest_pr_d[i] = alloc.write_dest_pr[s];
                        rob_index_d[i] = alloc.write_rob_index[s];
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // payload follows valid_q, no reset
    always_ff @(posedge CLK) begin
        op_q <= op_d;
        imm12_q <= imm12_d;
        a_pr_q <= a_pr_d;
        a_ready_q <= a_ready_d;
        b_pr_q <= b_pr_d;
        b_ready_q <= b_ready_d;
        dest_pr_q <= dest_pr_d;
        rob_index_q <= rob_index_d;
    end

    // --------------------------------------------------
    // checks
    a_no_overwrite: assert property (@(posedge CLK) disable iff (!nRST)
        (alloc.write_mask & valid_q) == '0);

    // occupancy is always 0..k-1
    a_contiguous: assert property (@(posedge CLK) disable iff (!nRST)
        (valid_q & (valid_q + 1'b1)) == '0);

    a_launch_head_valid: assert property (@(posedge CLK) disable iff (!nRST)
        launch_valid |-> valid_q[0]);

endmodule

// File: design/sysu_dq_top.sv
/* system unit dispatch queue top level
   allocator and entry array joined by the allocation bundle */

`timescale 1ns/10ps

module sysu_dq_top (
    input  logic                                                         CLK,
    input  logic                                                         nRST,

    // dispatch by way
    input  sysu_op_pkg::way_mask_t                                       dispatch_attempt,
    input  sysu_op_pkg::way_mask_t                                       dispatch_valid,
    input  sysu_op_pkg::sysu_op_t   [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] dispatch_op,
    input  sysu_op_pkg::imm12_t     [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] dispatch_imm12,
    input  sysu_op_pkg::pr_t        [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] dispatch_a_pr,
    input  sysu_op_pkg::way_mask_t                                       dispatch_a_ready,
    input  sysu_op_pkg::pr_t        [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] dispatch_b_pr,
    input  sysu_op_pkg::way_mask_t                                       dispatch_b_ready,
    input  sysu_op_pkg::pr_t        [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] dispatch_dest_pr,
    input  sysu_op_pkg::rob_index_t [sysu_dq_cfg_pkg::DISPATCH_WAYS-1:0] dispatch_rob_index,
    output sysu_op_pkg::way_mask_t                                       dispatch_ack,

    // writeback bus by bank
    input  logic [sysu_dq_cfg_pkg::PRF_BANK_COUNT-1:0]                   wb_valid,
    input  sysu_op_pkg::pr_upper_t [sysu_dq_cfg_pkg::PRF_BANK_COUNT-1:0] wb_upper_pr,

    // launch to the system unit
    input  logic                                                         launch_ready,
    output logic                                                         launch_valid,
    output sysu_op_pkg::sysu_op_t                                        launch_op,
    output sysu_op_pkg::imm12_t                                          launch_imm12,
    output sysu_op_pkg::pr_t                                             launch_a_pr,
    output sysu_op_pkg::pr_t                                             launch_b_pr,
    output sysu_op_pkg::pr_t                                             launch_dest_pr,
    output sysu_op_pkg::rob_index_t                                      launch_rob_index
);

    sysu_dq_alloc_if alloc_bus ();

    // --------------------------------------------------
    // way to entry allocation
    sysu_dq_alloc i_alloc (
        .attempt        (dispatch_attempt),
        .dispatch_valid (dispatch_valid),
        .op             (dispatch_op),
        .imm12          (dispatch_imm12),
        .a_pr           (dispatch_a_pr),
        .a_ready        (dispatch_a_ready),
        .b_pr           (dispatch_b_pr),
        .b_ready        (dispatch_b_ready),
        .dest_pr        (dispatch_dest_pr),
        .rob_index      (dispatch_rob_index),
        .ack            (dispatch_ack),
        .alloc          (alloc_bus.alloc)
    );

    // --------------------------------------------------
    // storage, wakeup and launch
    sysu_dq_entries i_entries (
        .CLK              (CLK),
        .nRST             (nRST),
        .alloc            (alloc_bus.entries),
        .wb_valid         (wb_valid),
        .wb_upper_pr      (wb_upper_pr),
        .launch_ready     (launch_ready),
        .launch_valid     (launch_valid),
        .launch_op        (launch_op),
        .launch_imm12     (launch_imm12),
        .launch_a_pr      (launch_a_pr),
        .launch_b_pr      (launch_b_pr),
        .launch_dest_pr   (launch_dest_pr),
        .launch_rob_index (launch_rob_index)
    );

endmodule

// File: verification/tb_clock_gen.sv
/* testbench clock and reset source, 100 ns period, reset held 10 cycles */

`timescale 1ns/10ps

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

// File: verification/sysu_dq_tb.sv
/* table-driven testbench for the system unit dispatch queue
   dispatch acks, ordered launch, back-pressure, writeback wakeup */

`timescale 1ns/10ps

module sysu_dq_tb;
    import sysu_dq_cfg_pkg::*;
    import sysu_op_pkg::*;

    typedef logic [7:0] tag_t;

    // one cycle of stimulus and the response expected in it
    typedef struct packed {
        way_mask_t attempt;
        way_mask_t valid;
        way_mask_t a_rdy;
        way_mask_t b_rdy;
        tag_t [DISPATCH_WAYS-1:0] tag;
        logic [PRF_BANK_COUNT-1:0] wb_valid;
        pr_upper_t [PRF_BANK_COUNT-1:0] wb_upper;
        logic launch_ready;
        way_mask_t exp_ack;
        logic exp_launch;
        tag_t exp_tag;
    } row_t;

    logic CLK;
    logic nRST;
    way_mask_t dispatch_attempt;
    way_mask_t dispatch_valid;
    sysu_op_t [DISPATCH_WAYS-1:0] dispatch_op;
    imm12_t [DISPATCH_WAYS-1:0] dispatch_imm12;
    pr_t [DISPATCH_WAYS-1:0] dispatch_a_pr;
    way_mask_t dispatch_a_ready;
    pr_t [DISPATCH_WAYS-1:0] dispatch_b_pr;
    way_mask_t dispatch_b_ready;
    pr_t [DISPATCH_WAYS-1:0] dispatch_dest_pr;
    rob_index_t [DISPATCH_WAYS-1:0] dispatch_rob_index;
    way_mask_t dispatch_ack;
    logic [PRF_BANK_COUNT-1:0] wb_valid;
    pr_upper_t [PRF_BANK_COUNT-1:0] wb_upper_pr;
    logic launch_ready;
    logic launch_valid;
    sysu_op_t launch_op;
    imm12_t launch_imm12;
    pr_t launch_a_pr;
    pr_t launch_b_pr;
    pr_t launch_dest_pr;
    rob_index_t launch_rob_index;

    row_t rows[$];
    integer seed;
    int cycle_count = 0;
    int cycle_limit = 1000;
    tag_t filler [8];

    tb_clock_gen i_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    sysu_dq_top i_dut (.*);

    // --------------------------------------------------
    // payload fields derived from a tag
    function automatic sysu_op_t op_of(tag_t tag);
        return tag[3:0];
    endfunction

    function automatic imm12_t imm_of(tag_t tag);
        return {tag[3:0], tag};
    endfunction

    function automatic pr_t a_pr_of(tag_t tag);
        return tag[5:0] ^ 6'h15;
    endfunction

    function automatic pr_t b_pr_of(tag_t tag);
        return tag[5:0] ^ 6'h2a;
    endfunction

    function automatic pr_t dest_of(tag_t tag);
        return tag[7:2];
    endfunction

    function automatic rob_index_t rob_of(tag_t tag);
        return ~tag[5:0];
    endfunction

    // writeback bus that hits the A register of a tag
    function automatic logic [3:0] wake_valid(tag_t tag);
        pr_t p;

        p = a_pr_of(tag);
        return 4'b0001 << p[LOG_PRF_BANK_COUNT-1:0];
    endfunction

    function automatic logic [15:0] wake_upper(tag_t tag);
        pr_t p;

        p = a_pr_of(tag);
        return 16'(p[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]) << (4 * int'(p[1:0]));
    endfunction

    // --------------------------------------------------
    // table construction
    task automatic add_row(input way_mask_t attempt, input way_mask_t valid,
                           input way_mask_t a_rdy, input way_mask_t b_rdy,
                           input logic [31:0] tags, input logic [3:0] wbv,
                           input logic [15:0] wbu, input logic lr,
                           input way_mask_t exp_ack, input logic exp_launch,
                           input tag_t exp_tag);
        row_t r;

        r.attempt = attempt;
        r.valid = valid;
        r.a_rdy = a_rdy;
        r.b_rdy = b_rdy;
        r.tag = tags;
        r.wb_valid = wbv;
        r.wb_upper = wbu;
        r.launch_ready = lr;
        r.exp_ack = exp_ack;
        r.exp_launch = exp_launch;
        r.exp_tag = exp_tag;
        rows.push_back(r);
    endtask

    task automatic add_idle_row(input logic lr, input logic exp_launch, input tag_t exp_tag);
        add_row(4'b0, 4'b0, 4'b0, 4'b0, 32'h0, 4'b0, 16'h0, lr, 4'b0, exp_launch, exp_tag);
    endtask

    task automatic build_table();
        for (int i = 0; i < 8; i++) begin
            filler[i] = 8'($random(seed));
        end
        // reset state, empty queue
        add_idle_row(1'b0, 1'b0, 8'h00);
        add_idle_row(1'b1, 1'b0, 8'h00);
        // fill all four, then full and held
        add_row(4'b1111, 4'b1111, 4'b1111, 4'b1111, {8'h43, 8'h32, 8'h21, 8'h10},
                4'b0, 16'h0, 1'b0, 4'b1111, 1'b0, 8'h00);
        add_row(4'b0001, 4'b0001, 4'b0001, 4'b0001, {24'h0, 8'h54},
                4'b0, 16'h0, 1'b0, 4'b0000, 1'b0, 8'h00);
        add_idle_row(1'b0, 1'b0, 8'h00);
        add_idle_row(1'b1, 1'b1, 8'h10);
        add_idle_row(1'b1, 1'b1, 8'h21);
        // two free entries, ways 1..3 ask
        add_row(4'b1110, 4'b1110, 4'b1110, 4'b1110, {filler[2], filler[1], filler[0], 8'h00},
                4'b0, 16'h0, 1'b0, 4'b0110, 1'b0, 8'h00);
        add_idle_row(1'b1, 1'b1, 8'h32);
        // dispatch while launching
        add_row(4'b0001, 4'b0001, 4'b0001, 4'b0001, {24'h0, filler[3]},
                4'b0, 16'h0, 1'b1, 4'b0001, 1'b1, 8'h43);
        add_row(4'b0011, 4'b0011, 4'b0011, 4'b0011, {16'h0, filler[7], filler[4]},
                4'b0, 16'h0, 1'b1, 4'b0001, 1'b1, filler[0]);
        add_idle_row(1'b1, 1'b1, filler[1]);
        add_row(4'b0011, 4'b0011, 4'b0011, 4'b0011, {16'h0, filler[6], filler[5]},
                4'b0, 16'h0, 1'b1, 4'b0011, 1'b1, filler[3]);
        add_idle_row(1'b1, 1'b1, filler[4]);
        add_idle_row(1'b1, 1'b1, filler[5]);
        add_idle_row(1'b1, 1'b1, filler[6]);
        // wakeup: head and second op wait on A
        add_row(4'b0111, 4'b0111, 4'b0100, 4'b0100, {8'h00, 8'h83, 8'h76, 8'h65},
                4'b0, 16'h0, 1'b1, 4'b0111, 1'b0, 8'h00);
        add_idle_row(1'b1, 1'b0, 8'h00);
        add_row(4'b0, 4'b0, 4'b0, 4'b0, 32'h0, wake_valid(8'h76), wake_upper(8'h76),
                1'b0, 4'b0, 1'b0, 8'h00);
        add_row(4'b0, 4'b0, 4'b0, 4'b0, 32'h0, wake_valid(8'h65), wake_upper(8'h65),
                1'b1, 4'b0, 1'b1, 8'h65);
        add_idle_row(1'b1, 1'b1, 8'h76);
        add_idle_row(1'b1, 1'b1, 8'h83);
        // no-operand op, then A-only op with B not ready
        add_row(4'b0011, 4'b0011, 4'b0010, 4'b0000, {16'h0, 8'ha5, 8'h98},
                4'b0, 16'h0, 1'b0, 4'b0011, 1'b0, 8'h00);
        add_idle_row(1'b1, 1'b1, 8'h98);
        add_idle_row(1'b1, 1'b1, 8'ha5);
        add_idle_row(1'b1, 1'b0, 8'h00);
    endtask

    // --------------------------------------------------
    // drive and compare
    task automatic drive_row(input row_t r);
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            dispatch_op[w] = op_of(r.tag[w]);
            dispatch_imm12[w] = imm_of(r.tag[w]);
            dispatch_a_pr[w] = a_pr_of(r.tag[w]);
            dispatch_b_pr[w] = b_pr_of(r.tag[w]);
            dispatch_dest_pr[w] = dest_of(r.tag[w]);
            dispatch_rob_index[w] = rob_of(r.tag[w]);
        end
        dispatch_attempt = r.attempt;
        dispatch_valid = r.valid;
        dispatch_a_ready = r.a_rdy;
        dispatch_b_ready = r.b_rdy;
        wb_valid = r.wb_valid;
        wb_upper_pr = r.wb_upper;
        launch_ready = r.launch_ready;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: time %0t signal %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // cycle budget: table rows plus reset plus margin
    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // main sequence
    initial begin
        seed = 32'h0024_f653;
        dispatch_attempt = '0;
        dispatch_valid = '0;
        dispatch_op = '0;
        dispatch_imm12 = '0;
        dispatch_a_pr = '0;
        dispatch_a_ready = '0;
        dispatch_b_pr = '0;
        dispatch_b_ready = '0;
        dispatch_dest_pr = '0;
        dispatch_rob_index = '0;
        wb_valid = '0;
        wb_upper_pr = '0;
        launch_ready = 1'b0;
        build_table();
        cycle_limit = rows.size() + 10 + 20;
        wait (nRST === 1'b1);
        foreach (rows[i]) begin
            @(negedge CLK);
            drive_row(rows[i]);
            // sample shortly before the next rising edge
            #40;
            check_value("dispatch_ack", 32'(rows[i].exp_ack), 32'(dispatch_ack));
            check_value("launch_valid", 32'(rows[i].exp_launch), 32'(launch_valid));
            if (rows[i].exp_launch) begin
                check_value("launch_op", 32'(op_of(rows[i].exp_tag)), 32'(launch_op));
                check_value("launch_imm12", 32'(imm_of(rows[i].exp_tag)), 32'(launch_imm12));
                check_value("launch_a_pr", 32'(a_pr_of(rows[i].exp_tag)), 32'(launch_a_pr));
                check_value("launch_b_pr", 32'(b_pr_of(rows[i].exp_tag)), 32'(launch_b_pr));
                check_value("launch_dest_pr", 32'(dest_of(rows[i].exp_tag)),
                            32'(launch_dest_pr));
                check_value("launch_rob_index", 32'(rob_of(rows[i].exp_tag)),
                            32'(launch_rob_index));
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: sysu_dq.f
design/sysu_dq_cfg_pkg.sv
design/sysu_op_pkg.sv
design/sysu_dq_alloc_if.sv
design/sysu_dq_alloc.sv
design/sysu_dq_entries.sv
design/sysu_dq_top.sv
verification/tb_clock_gen.sv
verification/sysu_dq_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= sysu_dq_tb
FILELIST  ?= sysu_dq.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
